// ==== vec_alu_defines.svh ====
`ifndef VEC_ALU_DEFINES_SVH
`define VEC_ALU_DEFINES_SVH

// datapath width of operands and result
`define VEC_DATA_WIDTH 64

// byte lanes in one word
`define VEC_LANES_B 8

// opcode field, same encoding as the ALU decoder
`define VEC_OPCODE_WIDTH 6

// lane mode field (b, h, w, d)
`define VEC_MODE_WIDTH 2

`endif

// ==== vec_types_pkg.sv ====
`include "vec_alu_defines.svh"

package vec_types_pkg;

    // lane width selector
    typedef enum logic [`VEC_MODE_WIDTH-1:0] {
        mode_b = 2'd0,  // 8-bit lanes
        mode_h = 2'd1,  // 16-bit lanes
        mode_w = 2'd2,  // 32-bit lanes
        mode_d = 2'd3   // one 64-bit lane
    } lane_mode_e;

    // one vector word seen as bytes, halves, words or a double word
    // lane 0 is the most significant lane in every view
    typedef union packed {
        logic [0:`VEC_LANES_B-1][7:0]   b;
        logic [0:`VEC_LANES_B/2-1][15:0] h;
        logic [0:`VEC_LANES_B/4-1][31:0] w;
        logic [`VEC_DATA_WIDTH-1:0]     d;
    } vec_word_u;

endpackage

// ==== vec_op_pkg.sv ====
`include "vec_alu_defines.svh"

package vec_op_pkg;

    import vec_types_pkg::*;

    // ALU function codes; 0 and 14 and up decode as unknown
    typedef enum logic [`VEC_OPCODE_WIDTH-1:0] {
        op_and   = 6'd1,
        op_or    = 6'd2,
        op_xor   = 6'd3,
        op_not   = 6'd4,
        op_mov   = 6'd5,
        op_add   = 6'd6,
        op_sub   = 6'd7,
        op_muleu = 6'd8,   // even lanes, unsigned widening
        op_mulou = 6'd9,   // odd lanes, unsigned widening
        op_sll   = 6'd10,
        op_srl   = 6'd11,
        op_sra   = 6'd12,
        op_rtth  = 6'd13   // swap lane halves
    } vec_opcode_e;

    // one ALU request, 136 bits
    typedef struct packed {
        vec_opcode_e opcode;
        lane_mode_e  lane_mode;
        vec_word_u   a;
        vec_word_u   b;
    } vec_op_req_t;

endpackage

// ==== lane_addsub.sv ====
`timescale 1ns/1ps
`include "vec_alu_defines.svh"

module lane_addsub
    import vec_types_pkg::*, vec_op_pkg::*;
(
    input  vec_op_req_t req,
    output vec_word_u   sum
);

    logic                         sub;
    logic [2:0]                   byte_mask;  // bytes per lane minus one
    logic [0:`VEC_LANES_B-1][7:0] b_eff;

    assign sub = (req.opcode == op_sub);

    // subtract as a + ~b + 1
    assign b_eff = sub ? ~req.b.b : req.b.b;

    always_comb begin
        case (req.lane_mode)
            mode_b:  byte_mask = 3'd0;
            mode_h:  byte_mask = 3'd1;
            mode_w:  byte_mask = 3'd3;
            default: byte_mask = 3'd7;
        endcase
    end

    // ripple from the least significant byte (index 7) upward
    always_comb begin
        logic carry;
        carry = 1'b0;
        for (int i = `VEC_LANES_B - 1; i >= 0; i--) begin
            // low byte of a lane starts a fresh chain
            if ((3'(i) & byte_mask) == byte_mask) begin
                carry = sub;
            end
            {carry, sum.b[i]} = {1'b0, req.a.b[i]} + {1'b0, b_eff[i]} + {8'd0, carry};
        end
    end

endmodule

// ==== lane_multiplier.sv ====
`timescale 1ns/1ps

module lane_multiplier
    import vec_types_pkg::*, vec_op_pkg::*;
(
    input  vec_op_req_t req,
    output vec_word_u   product
);

    logic             is_mul;
    logic             odd;           // pick lanes 1, 3, ...
    logic [31:0]      mul_a;
    logic [31:0]      mul_b;
    logic [0:3][15:0] prod_b;
    logic [0:1][31:0] prod_h;
    logic [63:0]      prod_w;

    assign is_mul = (req.opcode == op_muleu) || (req.opcode == op_mulou);
    assign odd    = (req.opcode == op_mulou);

    // gather the selected lanes into a half-width operand pair
    always_comb begin
        mul_a = '0;
        mul_b = '0;
        if (is_mul) begin
            case (req.lane_mode)
                mode_b: begin
                    for (int k = 0; k < 4; k++) begin
                        mul_a[31-8*k -: 8] = req.a.b[2*k+odd];
                        mul_b[31-8*k -: 8] = req.b.b[2*k+odd];
                    end
                end
                mode_h: begin
                    for (int k = 0; k < 2; k++) begin
                        mul_a[31-16*k -: 16] = req.a.h[2*k+odd];
                        mul_b[31-16*k -: 16] = req.b.h[2*k+odd];
                    end
                end
                mode_w: begin
                    mul_a = req.a.w[odd];
                    mul_b = req.b.w[odd];
                end
                default: begin
                    mul_a = '0;  // no widening for 64-bit lanes
                    mul_b = '0;
                end
            endcase
        end
    end

    always_comb begin
        for (int k = 0; k < 4; k++) begin
            prod_b[k] = 16'(mul_a[31-8*k -: 8]) * 16'(mul_b[31-8*k -: 8]);
        end
        for (int k = 0; k < 2; k++) begin
            prod_h[k] = 32'(mul_a[31-16*k -: 16]) * 32'(mul_b[31-16*k -: 16]);
        end
        prod_w = 64'(mul_a) * 64'(mul_b);
    end

    // products packed back in lane order
    always_comb begin
        case (req.lane_mode)
            mode_b:  product.d = prod_b;
            mode_h:  product.d = prod_h;
            mode_w:  product.d = prod_w;
            default: product.d = '0;
        endcase
    end

endmodule

// ==== lane_shifter.sv ====
`timescale 1ns/1ps

module lane_shifter
    import vec_types_pkg::*, vec_op_pkg::*;
(
    input  vec_op_req_t req,
    output vec_word_u   shifted
);

    // shift one lane held in the low width bits of x
    function automatic logic [63:0] shift_lane(
        input logic [63:0] x,
        input logic [5:0]  amt,
        input int unsigned width,
        input vec_opcode_e op
    );
        logic [63:0]        mask;
        logic [63:0]        ext;
        logic signed [63:0] sra_val;
        mask = (64'd1 << width) - 64'd1;  // wraps to all ones at 64
        ext  = (op == op_sra && x[width-1]) ? (x | ~mask) : x;
        sra_val = $signed(ext) >>> amt;
        case (op)
            op_sll:  return (ext << amt) & mask;
            op_srl:  return (ext >> amt) & mask;
            default: return sra_val & mask;
        endcase
    endfunction

    always_comb begin
        shifted = '0;
        case (req.opcode)
            op_sll, op_srl, op_sra: begin
                case (req.lane_mode)
                    mode_b: begin
                        for (int i = 0; i < 8; i++) begin
                            shifted.b[i] = 8'(shift_lane(64'(req.a.b[i]),
                                6'(req.b.b[i][2:0]), 8, req.opcode));
                        end
                    end
                    mode_h: begin
                        for (int i = 0; i < 4; i++) begin
                            shifted.h[i] = 16'(shift_lane(64'(req.a.h[i]),
                                6'(req.b.h[i][3:0]), 16, req.opcode));
                        end
                    end
                    mode_w: begin
                        for (int i = 0; i < 2; i++) begin
                            shifted.w[i] = 32'(shift_lane(64'(req.a.w[i]),
                                6'(req.b.w[i][4:0]), 32, req.opcode));
                        end
                    end
                    default: begin
                        shifted.d = shift_lane(req.a.d, req.b.d[5:0], 64, req.opcode);
                    end
                endcase
            end
            op_rtth: begin
                case (req.lane_mode)
                    mode_b: begin
                        for (int i = 0; i < 8; i++) begin
                            shifted.b[i] = {req.a.b[i][3:0], req.a.b[i][7:4]};
                        end
                    end
                    mode_h: begin
                        for (int i = 0; i < 4; i++) begin
                            shifted.h[i] = {req.a.h[i][7:0], req.a.h[i][15:8]};
                        end
                    end
                    mode_w: begin
                        for (int i = 0; i < 2; i++) begin
                            shifted.w[i] = {req.a.w[i][15:0], req.a.w[i][31:16]};
                        end
                    end
                    default: shifted.d = {req.a.d[31:0], req.a.d[63:32]};
                endcase
            end
            default: shifted = '0;
        endcase
    end

endmodule

// ==== vec_result_select.sv ====
`timescale 1ns/1ps

module vec_result_select
    import vec_types_pkg::*, vec_op_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        op_valid,
    input  vec_op_req_t req,
    input  vec_word_u   sum,
    input  vec_word_u   product,
    input  vec_word_u   shifted,
    output logic        result_valid,
    output vec_word_u   result
);

    vec_word_u next_result;

    // lane mode does not matter for the bitwise group
    always_comb begin
        case (req.opcode)
            op_and:   next_result.d = req.a.d & req.b.d;
            op_or:    next_result.d = req.a.d | req.b.d;
            op_xor:   next_result.d = req.a.d ^ req.b.d;
            op_not:   next_result.d = ~req.a.d;
            op_mov:   next_result.d = req.a.d;
            op_add,
            op_sub:   next_result = sum;
            op_muleu,
            op_mulou: next_result = product;
            op_sll,
            op_srl,
            op_sra,
            op_rtth:  next_result = shifted;
            default:  next_result.d = '0;  // unknown code
        endcase
    end

    // one result per accepted request, one cycle later
    always_ff @(posedge clk) begin
        if (reset) begin
            result_valid <= 1'b0;
            result       <= '0;
        end else begin
            result_valid <= op_valid;
            if (op_valid) begin
                result <= next_result;
            end
        end
    end

endmodule

// ==== vec_alu.sv ====
`timescale 1ns/1ps

module vec_alu
    import vec_types_pkg::*, vec_op_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        op_valid,
    input  vec_op_req_t req,
    output logic        result_valid,
    output vec_word_u   result
);

    vec_word_u sum;
    vec_word_u product;
    vec_word_u shifted;

    // add / sub with lane-split carry chain
    lane_addsub u_addsub (
        .req (req),
        .sum (sum)
    );

    // even / odd widening multiply
    lane_multiplier u_multiplier (
        .req     (req),
        .product (product)
    );

    // shifts and half swap
    lane_shifter u_shifter (
        .req     (req),
        .shifted (shifted)
    );

    vec_result_select u_result_select (
        .clk          (clk),
        .reset        (reset),
        .op_valid     (op_valid),
        .req          (req),
        .sum          (sum),
        .product      (product),
        .shifted      (shifted),
        .result_valid (result_valid),
        .result       (result)
    );

endmodule

// ==== vec_alu_tb.sv ====
`timescale 1ns/1ps

module vec_alu_tb
    import vec_types_pkg::*, vec_op_pkg::*;
;

    localparam int SEED           = 53;
    localparam int RESET_CYCLES   = 8;
    localparam int STIM_CYCLES    = 2000;
    localparam int TIMEOUT_CYCLES = STIM_CYCLES + RESET_CYCLES + 92;  // 2100

    logic        clk;
    logic        reset;
    logic        op_valid;
    vec_op_req_t req;
    logic        result_valid;
    vec_word_u   result;

    logic        checking;
    logic        exp_valid;
    vec_word_u   exp_result;
    int          cycle_count;
    int          error_count;
    int          check_count;
    int unsigned seed_sink;

    vec_alu uut (
        .clk          (clk),
        .reset        (reset),
        .op_valid     (op_valid),
        .req          (req),
        .result_valid (result_valid),
        .result       (result)
    );

    always #5 clk = ~clk;

    function automatic vec_word_u model_addsub(vec_word_u a, vec_word_u b,
                                               lane_mode_e mode, logic sub);
        vec_word_u r;
        r.d = '0;
        case (mode)
            mode_b: for (int i = 0; i < 8; i++) r.b[i] = sub ? a.b[i] - b.b[i] : a.b[i] + b.b[i];
            mode_h: for (int i = 0; i < 4; i++) r.h[i] = sub ? a.h[i] - b.h[i] : a.h[i] + b.h[i];
            mode_w: for (int i = 0; i < 2; i++) r.w[i] = sub ? a.w[i] - b.w[i] : a.w[i] + b.w[i];
            default: r.d = sub ? a.d - b.d : a.d + b.d;
        endcase
        return r;
    endfunction

    function automatic vec_word_u model_mul(vec_word_u a, vec_word_u b,
                                            lane_mode_e mode, logic odd);
        vec_word_u r;
        int        o;
        r.d = '0;
        o   = odd ? 1 : 0;
        case (mode)
            mode_b: for (int k = 0; k < 4; k++) r.h[k] = 16'(a.b[2*k+o]) * 16'(b.b[2*k+o]);
            mode_h: for (int k = 0; k < 2; k++) r.w[k] = 32'(a.h[2*k+o]) * 32'(b.h[2*k+o]);
            mode_w: r.d = 64'(a.w[o]) * 64'(b.w[o]);
            default: r.d = '0;  // no 128-bit products
        endcase
        return r;
    endfunction

    function automatic vec_word_u model_shift(vec_word_u a, vec_word_u b,
                                              lane_mode_e mode, vec_opcode_e op);
        vec_word_u          r;
        logic [5:0]         amt;
        logic signed [7:0]  sb;
        logic signed [15:0] sh;
        logic signed [31:0] sw;
        logic signed [63:0] sd;
        r.d = '0;
        case (mode)
            mode_b: for (int i = 0; i < 8; i++) begin
                sb  = a.b[i];
                amt = 6'(b.b[i][2:0]);
                r.b[i] = (op == op_sll) ? sb << amt : (op == op_srl) ? sb >> amt : sb >>> amt;
            end
            mode_h: for (int i = 0; i < 4; i++) begin
                sh  = a.h[i];
                amt = 6'(b.h[i][3:0]);
                r.h[i] = (op == op_sll) ? sh << amt : (op == op_srl) ? sh >> amt : sh >>> amt;
            end
            mode_w: for (int i = 0; i < 2; i++) begin
                sw  = a.w[i];
                amt = 6'(b.w[i][4:0]);
                r.w[i] = (op == op_sll) ? sw << amt : (op == op_srl) ? sw >> amt : sw >>> amt;
            end
            default: begin
                sd  = a.d;
                amt = b.d[5:0];
                r.d = (op == op_sll) ? sd << amt : (op == op_srl) ? sd >> amt : sd >>> amt;
            end
        endcase
        return r;
    endfunction

    // rotate each lane by half its width
    function automatic vec_word_u model_swap_halves(vec_word_u a, lane_mode_e mode);
        vec_word_u r;
        r.d = '0;
        case (mode)
            mode_b: for (int i = 0; i < 8; i++) r.b[i] = (a.b[i] << 4) | (a.b[i] >> 4);
            mode_h: for (int i = 0; i < 4; i++) r.h[i] = (a.h[i] << 8) | (a.h[i] >> 8);
            mode_w: for (int i = 0; i < 2; i++) r.w[i] = (a.w[i] << 16) | (a.w[i] >> 16);
            default: r.d = (a.d << 32) | (a.d >> 32);
        endcase
        return r;
    endfunction

    function automatic vec_word_u model_alu(vec_op_req_t q);
        vec_word_u r;
        r.d = '0;
        case (q.opcode)
            op_and:  r.d = q.a.d & q.b.d;
            op_or:   r.d = q.a.d | q.b.d;
            op_xor:  r.d = q.a.d ^ q.b.d;
            op_not:  r.d = ~q.a.d;
            op_mov:  r.d = q.a.d;
            op_add:  r = model_addsub(q.a, q.b, q.lane_mode, 1'b0);
            op_sub:  r = model_addsub(q.a, q.b, q.lane_mode, 1'b1);
            op_muleu: r = model_mul(q.a, q.b, q.lane_mode, 1'b0);
            op_mulou: r = model_mul(q.a, q.b, q.lane_mode, 1'b1);
            op_sll, op_srl, op_sra: r = model_shift(q.a, q.b, q.lane_mode, q.opcode);
            op_rtth: r = model_swap_halves(q.a, q.lane_mode);
            default: r.d = '0;  // unknown and dropped codes
        endcase
        return r;
    endfunction

    function automatic vec_op_req_t random_request();
        vec_op_req_t r;
        int unsigned pick;
        logic [5:0]  code;
        pick = $urandom_range(15);
        if (pick < 14) begin
            code = 6'(1 + $urandom_range(12));
        end else if (pick == 14) begin
            code = 6'd0;
        end else begin
            code = 6'(14 + $urandom_range(49));  // 14 to 63
        end
        r.opcode    = vec_opcode_e'(code);
        r.lane_mode = lane_mode_e'($urandom_range(3));
        r.a.d       = {$urandom, $urandom};
        r.b.d       = {$urandom, $urandom};
        return r;
    endfunction

    task automatic drive_request();
        op_valid <= ($urandom_range(3) != 0);  // busy 3 cycles in 4
        req      <= random_request();
    endtask

    // expected output register with reset priority
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        checking    <= 1'b1;
        if (reset) begin
            exp_valid  <= 1'b0;
            exp_result <= '0;
        end else begin
            exp_valid <= op_valid;
            if (op_valid) exp_result <= model_alu(req);
        end
    end

    always @(negedge clk) begin
        if (checking) begin
            check_count++;
            assert (result_valid === exp_valid) else begin
                error_count++;
                $display("FAIL time=%0t signal=result_valid expected=%b actual=%b",
                         $time, exp_valid, result_valid);
            end
            assert (result === exp_result) else begin
                error_count++;
                $display("FAIL time=%0t signal=result expected=%h actual=%h",
                         $time, exp_result.d, result.d);
            end
        end
    end

    initial begin
        seed_sink = $urandom(SEED);
        clk      = 1'b0;
        reset    = 1'b1;
        op_valid = 1'b0;
        req      = '0;
        checking = 1'b0;
        // random traffic during reset is ignored
        for (int c = 0; c < RESET_CYCLES; c++) begin
            @(posedge clk);
            drive_request();
        end
        reset <= 1'b0;
        for (int c = 0; c < STIM_CYCLES; c++) begin
            @(posedge clk);
            drive_request();
        end
        @(posedge clk);
        op_valid <= 1'b0;
        repeat (3) @(posedge clk);
        $display("checks: %0d  errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    initial begin
        wait (cycle_count >= TIMEOUT_CYCLES);
        $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

// ==== vec_alu.f ====
+incdir+.
vec_types_pkg.sv
vec_op_pkg.sv
lane_addsub.sv
lane_multiplier.sv
lane_shifter.sv
vec_result_select.sv
vec_alu.sv
vec_alu_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with Verilator, run it into sim.log, then look for the pass line

verilator --binary --timing --assert -Wno-fatal -f vec_alu.f --top-module vec_alu_tb \
    && ./obj_dir/Vvec_alu_tb > sim.log 2>&1 \
    || { echo "build or simulation run failed"; exit 1; }

cat sim.log

grep -q "ALL CHECKS PASSED" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }
